/* verilog/rv_pkg.sv */
/*
  Shared RV32I definitions: widths, opcodes, ALU and select codes.
  Only the base integer formats are described, no compressed encodings.
*/
package rv_pkg;

  localparam int unsigned XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // Major opcodes ------------------
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // ALU functions ------------------
  localparam logic [3:0] ALU_ADD    = 4'd0;
  localparam logic [3:0] ALU_SUB    = 4'd1;
  localparam logic [3:0] ALU_SLL    = 4'd2;
  localparam logic [3:0] ALU_SLT    = 4'd3;
  localparam logic [3:0] ALU_SLTU   = 4'd4;
  localparam logic [3:0] ALU_XOR    = 4'd5;
  localparam logic [3:0] ALU_SRL    = 4'd6;
  localparam logic [3:0] ALU_SRA    = 4'd7;
  localparam logic [3:0] ALU_OR     = 4'd8;
  localparam logic [3:0] ALU_AND    = 4'd9;
  localparam logic [3:0] ALU_PASS_B = 4'd10;

  // Datapath selects ---------------
  localparam logic OPA_RS1 = 1'b0;
  localparam logic OPA_PC  = 1'b1;
  localparam logic OPB_RS2 = 1'b0;
  localparam logic OPB_IMM = 1'b1;

  localparam logic [1:0] NPC_PLUS4  = 2'd0;
  localparam logic [1:0] NPC_TARGET = 2'd1;
  localparam logic [1:0] NPC_JALR   = 2'd2;

  localparam logic [1:0] WB_ALU = 2'd0;
  localparam logic [1:0] WB_MEM = 2'd1;
  localparam logic [1:0] WB_PC4 = 2'd2;
  localparam logic [1:0] WB_IMM = 2'd3;

  // Instruction formats ------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rv_s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_j_fmt_t;

  // One instruction word, six views
  typedef union packed {
    rv_r_fmt_t r;
    rv_i_fmt_t i;
    rv_s_fmt_t s;
    rv_b_fmt_t b;
    rv_u_fmt_t u;
    rv_j_fmt_t j;
  } rv_inst_t;

endpackage

/* verilog/rv_regfile.sv */
/*
  32 x 32 register file, combinational reads, one write port.
  x0 is cleared by reset and writes to it are dropped.
*/
`timescale 1ns/1ps

module rv_regfile (
  input  logic                     clock,
  input  logic                     arst_n,
  input  logic [4:0]               rs1_addr,
  input  logic [4:0]               rs2_addr,
  input  logic [4:0]               rd_addr,
  input  logic [rv_pkg::XLEN-1:0]  rd_data,
  input  logic                     rd_write,
  output logic [rv_pkg::XLEN-1:0]  rs1_data,
  output logic [rv_pkg::XLEN-1:0]  rs2_data
);

  logic [rv_pkg::XLEN-1:0] regs [0:31];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (rd_write && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  // x0 stays zero on both ports, even right after a write to it
  a_x0_zero: assert property (
    @(posedge clock) disable iff (!arst_n)
    (rs1_addr == 5'd0 -> rs1_data == '0) && (rs2_addr == 5'd0 -> rs2_data == '0)
  ) else $error("x0 read back nonzero");

endmodule

/* verilog/rv_alu.sv */
/*
  Combinational 32-bit ALU. Shift amount is operand_b[4:0].
  Unused function codes give zero.
*/
`timescale 1ns/1ps

module rv_alu (
  input  logic [3:0]               alu_fn,
  input  logic [rv_pkg::XLEN-1:0]  operand_a,
  input  logic [rv_pkg::XLEN-1:0]  operand_b,
  output logic [rv_pkg::XLEN-1:0]  result,
  output logic                     zero
);

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_fn)
      rv_pkg::ALU_ADD:    result = operand_a + operand_b;
      rv_pkg::ALU_SUB:    result = operand_a - operand_b;
      rv_pkg::ALU_SLL:    result = operand_a << shamt;
      rv_pkg::ALU_SLT: begin
        result = {31'd0, $signed(operand_a) < $signed(operand_b)};
      end
      rv_pkg::ALU_SLTU:   result = {31'd0, operand_a < operand_b};
      rv_pkg::ALU_XOR:    result = operand_a ^ operand_b;
      rv_pkg::ALU_SRL:    result = operand_a >> shamt;
      // Arithmetic shift keeps the sign bit
      rv_pkg::ALU_SRA:    result = $unsigned($signed(operand_a) >>> shamt);
      rv_pkg::ALU_OR:     result = operand_a | operand_b;
      rv_pkg::ALU_AND:    result = operand_a & operand_b;
      rv_pkg::ALU_PASS_B: result = operand_b;
      default:            result = '0;
    endcase
  end

  // Used by control for branch decisions
  assign zero = (result == '0);

endmodule

/* verilog/rv_imm_gen.sv */
/*
  Immediate generator for I, S, B, U and J formats.
  Opcodes without an immediate give zero.
*/
`timescale 1ns/1ps

module rv_imm_gen (
  input  rv_pkg::rv_inst_t         inst,
  output logic [rv_pkg::XLEN-1:0]  imm
);

  always_comb begin
    case (inst.r.opcode)
      rv_pkg::OPC_JALR, rv_pkg::OPC_LOAD, rv_pkg::OPC_OP_IMM: begin
        imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
      end
      rv_pkg::OPC_STORE: begin
        imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
      end
      // Branch and jump offsets are in units of two bytes
      rv_pkg::OPC_BRANCH: begin
        imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
      end
      rv_pkg::OPC_JAL: begin
        imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
               inst.j.imm_11, inst.j.imm_10_1, 1'b0};
      end
      rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
        imm = {inst.u.imm_31_12, 12'd0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

/* verilog/rv_datapath.sv */
/*
  Single-cycle datapath. PC, operand, next-PC and writeback muxes.
  JALR clears only bit 0 of the target; the PC is assumed word-aligned.
*/
`timescale 1ns/1ps

module rv_datapath (
  input  logic                     clock,
  input  logic                     arst_n,
  input  rv_pkg::rv_inst_t         inst,
  input  logic                     pc_write,
  input  logic                     reg_write,
  input  logic [3:0]               alu_fn,
  input  logic                     opa_sel,
  input  logic                     opb_sel,
  input  logic [1:0]               npc_sel,
  input  logic [1:0]               wb_sel,
  input  logic [rv_pkg::XLEN-1:0]  dmem_rdata,
  output logic [rv_pkg::XLEN-1:0]  pc,
  output logic [rv_pkg::XLEN-1:0]  alu_result,
  output logic [rv_pkg::XLEN-1:0]  rs2_data,
  output logic                     alu_zero
);

  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] imm;
  logic [rv_pkg::XLEN-1:0] pc_plus4;
  logic [rv_pkg::XLEN-1:0] pc_target;
  logic [rv_pkg::XLEN-1:0] operand_a;
  logic [rv_pkg::XLEN-1:0] operand_b;
  logic [rv_pkg::XLEN-1:0] next_pc;
  logic [rv_pkg::XLEN-1:0] rd_data;

  // Program counter ------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc <= rv_pkg::RESET_PC;
    end else if (pc_write) begin
      pc <= next_pc;
    end
  end

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    case (npc_sel)
      rv_pkg::NPC_TARGET: next_pc = pc_target;
      rv_pkg::NPC_JALR:   next_pc = {alu_result[rv_pkg::XLEN-1:1], 1'b0};
      default:            next_pc = pc_plus4;
    endcase
  end

  // Operands and writeback -----------
  assign operand_a = (opa_sel == rv_pkg::OPA_PC)  ? pc  : rs1_data;
  assign operand_b = (opb_sel == rv_pkg::OPB_IMM) ? imm : rs2_data;

  always_comb begin
    case (wb_sel)
      rv_pkg::WB_MEM: rd_data = dmem_rdata;
      rv_pkg::WB_PC4: rd_data = pc_plus4;
      rv_pkg::WB_IMM: rd_data = imm;
      default:        rd_data = alu_result;
    endcase
  end

  // Blocks ---------------------------
  rv_regfile i_regfile (
    .clock    (clock),
    .arst_n   (arst_n),
    .rs1_addr (inst.r.rs1),
    .rs2_addr (inst.r.rs2),
    .rd_addr  (inst.r.rd),
    .rd_data  (rd_data),
    .rd_write (reg_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu i_alu (
    .alu_fn    (alu_fn),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (alu_result),
    .zero      (alu_zero)
  );

  rv_imm_gen i_imm_gen (
    .inst (inst),
    .imm  (imm)
  );

  // Instruction fetch assumes word alignment
  a_pc_aligned: assert property (
    @(posedge clock) disable iff (!arst_n)
    pc[1:0] == 2'b00
  ) else $error("PC not word-aligned: %h", pc);

endmodule

/* verilog/rv_control.sv */
/*
  Single-cycle decoder. Unknown opcodes only advance the PC.
  Loads and stores hold the PC and rd writes until dmem_ready.
*/
`timescale 1ns/1ps

module rv_control (
  input  logic             clock,
  input  logic             arst_n,
  input  rv_pkg::rv_inst_t inst,
  input  logic             alu_zero,
  input  logic             dmem_ready,
  output logic             pc_write,
  output logic             reg_write,
  output logic [3:0]       alu_fn,
  output logic             opa_sel,
  output logic             opb_sel,
  output logic [1:0]       npc_sel,
  output logic [1:0]       wb_sel,
  output logic             dmem_valid,
  output logic             dmem_write
);

  logic run;
  logic writes_rd;
  logic is_mem;
  logic taken;
  logic [3:0] arith_fn;

  // First cycle after reset is a bubble
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // funct7[5] picks SUB/SRA; SUB only exists for register operands
  always_comb begin
    case (inst.r.funct3)
      3'b000: begin
        arith_fn = (inst.r.opcode == rv_pkg::OPC_OP && inst.r.funct7[5]) ?
                   rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      end
      3'b001: arith_fn = rv_pkg::ALU_SLL;
      3'b010: arith_fn = rv_pkg::ALU_SLT;
      3'b011: arith_fn = rv_pkg::ALU_SLTU;
      3'b100: arith_fn = rv_pkg::ALU_XOR;
      3'b101: arith_fn = inst.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110: arith_fn = rv_pkg::ALU_OR;
      default: arith_fn = rv_pkg::ALU_AND;
    endcase
  end

  // Branch compare result sits in alu_zero; funct3 bits 0 and 2 flip its sense
  assign taken = alu_zero ^ inst.b.funct3[0] ^ inst.b.funct3[2];

  always_comb begin
    alu_fn     = rv_pkg::ALU_ADD;
    opa_sel    = rv_pkg::OPA_RS1;
    opb_sel    = rv_pkg::OPB_IMM;
    npc_sel    = rv_pkg::NPC_PLUS4;
    wb_sel     = rv_pkg::WB_ALU;
    writes_rd  = 1'b0;
    is_mem     = 1'b0;
    dmem_write = 1'b0;
    case (inst.r.opcode)
      rv_pkg::OPC_LUI: begin
        alu_fn    = rv_pkg::ALU_PASS_B;
        wb_sel    = rv_pkg::WB_IMM;
        writes_rd = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        opa_sel   = rv_pkg::OPA_PC;
        writes_rd = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        npc_sel   = rv_pkg::NPC_TARGET;
        wb_sel    = rv_pkg::WB_PC4;
        writes_rd = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        npc_sel   = rv_pkg::NPC_JALR;
        wb_sel    = rv_pkg::WB_PC4;
        writes_rd = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        opb_sel = rv_pkg::OPB_RS2;
        case (inst.b.funct3[2:1])
          2'b10:   alu_fn = rv_pkg::ALU_SLT;
          2'b11:   alu_fn = rv_pkg::ALU_SLTU;
          default: alu_fn = rv_pkg::ALU_SUB;
        endcase
        npc_sel = taken ? rv_pkg::NPC_TARGET : rv_pkg::NPC_PLUS4;
      end
      rv_pkg::OPC_LOAD: begin
        wb_sel    = rv_pkg::WB_MEM;
        writes_rd = 1'b1;
        is_mem    = 1'b1;
      end
      rv_pkg::OPC_STORE: begin
        is_mem     = 1'b1;
        dmem_write = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        alu_fn    = arith_fn;
        writes_rd = 1'b1;
      end
      rv_pkg::OPC_OP: begin
        alu_fn    = arith_fn;
        opb_sel   = rv_pkg::OPB_RS2;
        writes_rd = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Memory ops complete on the handshake cycle only
  assign dmem_valid = run & is_mem;
  assign pc_write   = run & (~is_mem | dmem_ready);
  assign reg_write  = pc_write & writes_rd;

  // A pending request is never withdrawn
  a_valid_held: assert property (
    @(posedge clock) disable iff (!arst_n)
    dmem_valid && !dmem_ready |=> dmem_valid
  ) else $error("dmem_valid dropped before dmem_ready");

endmodule

/* verilog/rv_core.sv */
/*
  RV32I single-cycle core. Instruction memory is read combinationally.
  Data memory uses valid/ready; only word accesses are supported.
*/
`timescale 1ns/1ps

module rv_core (
  input  logic                     clock,
  input  logic                     arst_n,
  output logic [rv_pkg::XLEN-1:0]  imem_addr,
  input  logic [rv_pkg::XLEN-1:0]  imem_data,
  output logic                     dmem_valid,
  output logic                     dmem_write,
  output logic [rv_pkg::XLEN-1:0]  dmem_addr,
  output logic [rv_pkg::XLEN-1:0]  dmem_wdata,
  input  logic                     dmem_ready,
  input  logic [rv_pkg::XLEN-1:0]  dmem_rdata
);

  logic       pc_write;
  logic       reg_write;
  logic [3:0] alu_fn;
  logic       opa_sel;
  logic       opb_sel;
  logic [1:0] npc_sel;
  logic [1:0] wb_sel;
  logic       alu_zero;

  rv_control i_control (
    .clock      (clock),
    .arst_n     (arst_n),
    .inst       (imem_data),
    .alu_zero   (alu_zero),
    .dmem_ready (dmem_ready),
    .pc_write   (pc_write),
    .reg_write  (reg_write),
    .alu_fn     (alu_fn),
    .opa_sel    (opa_sel),
    .opb_sel    (opb_sel),
    .npc_sel    (npc_sel),
    .wb_sel     (wb_sel),
    .dmem_valid (dmem_valid),
    .dmem_write (dmem_write)
  );

  // Address comes from the ALU, store data from rs2
  rv_datapath i_datapath (
    .clock      (clock),
    .arst_n     (arst_n),
    .inst       (imem_data),
    .pc_write   (pc_write),
    .reg_write  (reg_write),
    .alu_fn     (alu_fn),
    .opa_sel    (opa_sel),
    .opb_sel    (opb_sel),
    .npc_sel    (npc_sel),
    .wb_sel     (wb_sel),
    .dmem_rdata (dmem_rdata),
    .pc         (imem_addr),
    .alu_result (dmem_addr),
    .rs2_data   (dmem_wdata),
    .alu_zero   (alu_zero)
  );

endmodule

/* verif/rv_core_tb.sv */
/*
  Directed tests for the RV32I core. Programs are hand-assembled into imem.
  Data memory answers with 0 to 3 cycles of random ready delay.
  Word accesses only, addresses below 1 KiB.
*/
`timescale 1ns/1ps

module rv_core_tb;

  localparam int MAX_CYCLES = 4000;

  logic        clock;
  logic        arst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        dmem_valid;
  logic        dmem_write;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_ready;
  logic [31:0] dmem_rdata;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  int          ptr;
  int          errors;
  int          cycles;
  integer      seed;

  // Memory model state
  logic        busy;
  int          wait_left;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  logic        req_write;

  rv_core i_dut (
    .clock      (clock),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_valid (dmem_valid),
    .dmem_write (dmem_write),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_ready (dmem_ready),
    .dmem_rdata (dmem_rdata)
  );

  assign imem_data = imem[imem_addr[9:2]];

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Instruction encoders ----------
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Reference results from the RV32I rules
  function automatic logic [31:0] ref_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] fill_value(int idx);
    return 32'hc0de_0000 | idx;
  endfunction

  // Data memory model -------------
  always @(posedge clock) begin
    if (!arst_n) begin
      busy = 1'b0;
    end else if (dmem_valid && dmem_ready) begin
      if (dmem_write) begin
        dmem[dmem_addr[9:2]] = dmem_wdata;
      end
      busy = 1'b0;
    end
    #1;
    dmem_ready = 1'b0;
    if (arst_n && dmem_valid) begin
      if (!busy) begin
        busy      = 1'b1;
        wait_left = $random(seed) & 3;
        req_addr  = dmem_addr;
        req_wdata = dmem_wdata;
        req_write = dmem_write;
      end else begin
        if (dmem_addr !== req_addr) begin
          errors++;
          $display("[ERROR] %0t dmem_addr expected %h got %h", $time, req_addr, dmem_addr);
        end
        if (dmem_write !== req_write) begin
          errors++;
          $display("[ERROR] %0t dmem_write expected %b got %b", $time, req_write, dmem_write);
        end
        if (req_write && dmem_wdata !== req_wdata) begin
          errors++;
          $display("[ERROR] %0t dmem_wdata expected %h got %h", $time, req_wdata, dmem_wdata);
        end
      end
      if (wait_left == 0) begin
        dmem_ready = 1'b1;
        dmem_rdata = dmem[dmem_addr[9:2]];
      end else begin
        wait_left--;
      end
    end
  end

  // Run limit
  always @(posedge clock) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the core never settled", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Test helpers ------------------
  task automatic emit(logic [31:0] word);
    imem[ptr] = word;
    ptr++;
  endtask

  task automatic store_slot(logic [4:0] rs2, int slot);
    emit(enc_s(12'(slot * 4), rs2, 5'd0));
  endtask

  task automatic load_const(logic [4:0] rd, logic [31:0] val);
    logic [31:0] upper;
    upper = (val + 32'h800) >> 12;
    emit({upper[19:0], rd, rv_pkg::OPC_LUI});
    emit(enc_i(val[11:0], rd, 3'b000, rd, rv_pkg::OPC_OP_IMM));
  endtask

  // Holds the core in reset and clears both memories
  task automatic start_test(string name);
    @(posedge clock);
    #1;
    arst_n = 1'b0;
    $display("Test: %s", name);
    for (int k = 0; k < 256; k++) begin
      imem[k] = enc_i(12'(k), 5'd0, 3'b000, 5'd0, rv_pkg::OPC_OP_IMM);
      dmem[k] = fill_value(k);
    end
    ptr = 0;
  endtask

  task automatic run_program();
    int          still;
    logic [31:0] last;
    logic [31:0] end_addr;
    end_addr = 32'(ptr * 4);
    emit(enc_j(21'd0, 5'd0));
    repeat (2) @(posedge clock);
    #1;
    arst_n = 1'b1;
    still  = 0;
    last   = imem_addr;
    while (still < 8) begin
      @(posedge clock);
      #1;
      if (imem_addr == last) begin
        still++;
      end else begin
        still = 0;
        last  = imem_addr;
      end
    end
    // The program must settle on its closing self-jump
    if (imem_addr !== end_addr) begin
      errors++;
      $display("[ERROR] %0t imem_addr expected %h got %h", $time, end_addr, imem_addr);
    end
  endtask

  task automatic check_word(int slot, string name, logic [31:0] expected);
    if (dmem[slot] !== expected) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, dmem[slot]);
    end
  endtask

  // Tests -------------------------
  task automatic test_imm_ops();
    logic [31:0] a;
    logic [31:0] pc_auipc;
    a = sext12(12'hb2e);
    start_test("immediate ops");
    emit(enc_i(12'hb2e, 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h005, 5'd1, 3'b010, 5'd2, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h005, 5'd1, 3'b011, 5'd3, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h5a5, 5'd1, 3'b100, 5'd4, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h0f0, 5'd1, 3'b110, 5'd5, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h7ff, 5'd1, 3'b111, 5'd6, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h007, 5'd1, 3'b001, 5'd7, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h009, 5'd1, 3'b101, 5'd8, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h409, 5'd1, 3'b101, 5'd9, rv_pkg::OPC_OP_IMM));
    emit({20'habcde, 5'd10, rv_pkg::OPC_LUI});
    pc_auipc = 32'(ptr * 4);
    emit({20'h12345, 5'd11, rv_pkg::OPC_AUIPC});
    for (int r = 1; r <= 11; r++) begin
      store_slot(5'(r), r);
    end
    run_program();
    check_word(1, "addi", a);
    check_word(2, "slti", ($signed(a) < 5) ? 32'd1 : 32'd0);
    check_word(3, "sltiu", (a < 32'd5) ? 32'd1 : 32'd0);
    check_word(4, "xori", a ^ sext12(12'h5a5));
    check_word(5, "ori", a | sext12(12'h0f0));
    check_word(6, "andi", a & sext12(12'h7ff));
    check_word(7, "slli", a << 7);
    check_word(8, "srli", a >> 9);
    check_word(9, "srai", 32'($signed(a) >>> 9));
    check_word(10, "lui", 32'habcd_e000);
    check_word(11, "auipc", pc_auipc + 32'h1234_5000);
  endtask

  task automatic test_reg_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic        alt;
    a = $random(seed) | 32'h8000_0000;
    b = $random(seed);
    start_test("register ops");
    load_const(5'd1, a);
    load_const(5'd2, b);
    load_const(5'd3, 32'd31);
    load_const(5'd4, 32'h45);
    // Slots 0..7 plain ops, 8 and 9 the SUB and SRA variants
    for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
      alt = (k >= 8);
      emit(enc_r({1'b0, alt, 5'd0}, 5'd2, 5'd1, f3, 5'd10));
      store_slot(5'd10, k);
    end
    emit(enc_r(7'h00, 5'd3, 5'd1, 3'b001, 5'd10));
    store_slot(5'd10, 10);
    emit(enc_r(7'h20, 5'd3, 5'd1, 3'b101, 5'd10));
    store_slot(5'd10, 11);
    emit(enc_r(7'h00, 5'd4, 5'd1, 3'b101, 5'd10));
    store_slot(5'd10, 12);
    emit(enc_r(7'h20, 5'd4, 5'd1, 3'b101, 5'd10));
    store_slot(5'd10, 13);
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    store_slot(5'd0, 14);
    run_program();
    for (int k = 0; k < 10; k++) begin
      f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
      check_word(k, $sformatf("op f3=%0d alt=%0d", f3, k >= 8), ref_op(f3, k >= 8, a, b));
    end
    check_word(10, "sll by 31", ref_op(3'b001, 1'b0, a, 32'd31));
    check_word(11, "sra by 31", ref_op(3'b101, 1'b1, a, 32'd31));
    check_word(12, "srl by 0x45", ref_op(3'b101, 1'b0, a, 32'h45));
    check_word(13, "sra by 0x45", ref_op(3'b101, 1'b1, a, 32'h45));
    check_word(14, "x0", 32'd0);
  endtask

  task automatic test_branches();
    logic [2:0]  f3s  [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    logic [4:0]  rs1s [12] = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
    logic [4:0]  rs2s [12] = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
    logic [31:0] vals [4]  = '{0, 32'hffff_fffd, 5, 5};
    logic        taken;
    start_test("branches");
    emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h005, 5'd0, 3'b000, 5'd2, rv_pkg::OPC_OP_IMM));
    emit(enc_i(12'h005, 5'd0, 3'b000, 5'd3, rv_pkg::OPC_OP_IMM));
    for (int k = 0; k < 12; k++) begin
      emit(enc_b(13'd16, rs2s[k], rs1s[k], f3s[k]));
      emit(enc_i(12'(12'h100 + k), 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM));
      store_slot(5'd5, 2 * k);
      emit(enc_j(21'd12, 5'd0));
      emit(enc_i(12'(12'h200 + k), 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM));
      store_slot(5'd5, 2 * k + 1);
    end
    run_program();
    for (int k = 0; k < 12; k++) begin
      taken = branch_taken(f3s[k], vals[rs1s[k]], vals[rs2s[k]]);
      check_word(2 * k, $sformatf("branch %0d fall-through", k),
                 taken ? fill_value(2 * k) : 32'h100 + k);
      check_word(2 * k + 1, $sformatf("branch %0d taken", k),
                 taken ? 32'h200 + k : fill_value(2 * k + 1));
    end
  endtask

  task automatic test_jumps();
    start_test("jumps");
    emit(enc_j(21'd12, 5'd1));                                        // 0 jumps to 3
    emit(enc_i(12'h111, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM));     // 1
    store_slot(5'd5, 3);                                              // 2
    store_slot(5'd1, 0);                                              // 3
    emit(enc_i(12'd33, 5'd0, 3'b000, 5'd6, rv_pkg::OPC_OP_IMM));      // 4 odd 8*4+1
    emit(enc_i(12'd0, 5'd6, 3'b000, 5'd2, rv_pkg::OPC_JALR));         // 5 jumps to 8
    emit(enc_i(12'h222, 5'd0, 3'b000, 5'd5, rv_pkg::OPC_OP_IMM));     // 6
    store_slot(5'd5, 4);                                              // 7
    store_slot(5'd2, 1);                                              // 8
    emit(enc_i(12'd51, 5'd0, 3'b000, 5'd7, rv_pkg::OPC_OP_IMM));      // 9
    emit(enc_i(12'hffe, 5'd7, 3'b000, 5'd3, rv_pkg::OPC_JALR));       // 10 target 49 lands on 12
    store_slot(5'd0, 5);                                              // 11
    store_slot(5'd3, 2);                                              // 12
    run_program();
    check_word(0, "jal link", 32'd4);
    check_word(1, "jalr link", 32'd24);
    check_word(2, "jalr odd link", 32'd44);
    check_word(3, "skipped after jal", fill_value(3));
    check_word(4, "skipped after jalr", fill_value(4));
    check_word(5, "skipped after odd jalr", fill_value(5));
  endtask

  task automatic test_load_store();
    logic [31:0] a;
    logic [31:0] b;
    a = $random(seed);
    b = $random(seed);
    start_test("loads and stores");
    dmem[32] = a;
    dmem[33] = b;
    emit(enc_i(12'd128, 5'd0, 3'b010, 5'd1, rv_pkg::OPC_LOAD));
    emit(enc_i(12'd132, 5'd0, 3'b010, 5'd2, rv_pkg::OPC_LOAD));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    store_slot(5'd3, 0);
    store_slot(5'd1, 1);
    emit(enc_i(12'd0, 5'd0, 3'b010, 5'd4, rv_pkg::OPC_LOAD));
    emit(enc_i(12'd1, 5'd4, 3'b000, 5'd4, rv_pkg::OPC_OP_IMM));
    store_slot(5'd4, 2);
    emit(enc_i(12'd4, 5'd0, 3'b010, 5'd5, rv_pkg::OPC_LOAD));
    emit(enc_r(7'h20, 5'd2, 5'd5, 3'b000, 5'd6));
    store_slot(5'd6, 3);
    // Base register plus negative offset
    emit(enc_i(12'd256, 5'd0, 3'b000, 5'd7, rv_pkg::OPC_OP_IMM));
    emit(enc_s(12'hffc, 5'd3, 5'd7));
    emit(enc_i(12'hffc, 5'd7, 3'b010, 5'd8, rv_pkg::OPC_LOAD));
    store_slot(5'd8, 4);
    run_program();
    check_word(0, "load sum", a + b);
    check_word(1, "load copy", a);
    check_word(2, "reload plus one", a + b + 1);
    check_word(3, "reload diff", a - b);
    check_word(63, "offset store", a + b);
    check_word(4, "offset reload", a + b);
  endtask

  initial begin
    seed       = 32'h43e5_cb4f;
    errors     = 0;
    cycles     = 0;
    busy       = 1'b0;
    wait_left  = 0;
    arst_n     = 1'b0;
    dmem_ready = 1'b0;
    dmem_rdata = 32'd0;
    test_imm_ops();
    test_reg_ops();
    test_branches();
    test_jumps();
    test_load_store();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* vlog.f */
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_imm_gen.sv
verilog/rv_datapath.sv
verilog/rv_control.sv
verilog/rv_core.sv
verif/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= rv_core_tb
RTL_TOP   ?= rv_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi
	@grep -q "PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
